// File: dv/rob_tests.txt
# cmd then hex args: D n pc | W | R (lfsr order) | B k target | E k cause | I n
# S pc trap epc cause (expected squash) | T test_id ; k counts from the oldest entry
D 8 1000
R
T 1
D 10 2000
R
D 6 3000
W
T 2
D 6 4000
B 2 8000
W
S 8000 0 0 0
T 3
D 6 5000
E 3 5
W
S 700 1 500c 5
T 4
D 6 6000
E 4 2
B 1 9000
W
S 9000 0 0 0
T 5
D 6 6100
B 3 a000
E 2 7
W
S 700 1 6108 7
T 6
D 5 7000
I 2
W
T 7

// File: tb.f
+incdir+design
design/rob_pkg.sv
design/rob_entry_queue.sv
design/oldest_mispred_tracker.sv
design/oldest_except_tracker.sv
design/commit_ctrl.sv
design/rob_top.sv
dv/rob_chk.sv
dv/rob_tb.sv

// File: dv/rob_tb.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob_tb
    import rob_pkg::*;
();

    logic clk = 1'b0;
    logic rst;
    logic [`DISP_WIDTH-1:0] i_disp_vld;
    pc_t [`DISP_WIDTH-1:0] i_disp_pc;
    rob_idx_t [`DISP_WIDTH-1:0] o_alloc_idx;
    logic [`WB_PORTS-1:0] i_wb_vld;
    rob_idx_t [`WB_PORTS-1:0] i_wb_idx;
    logic i_br_vld;
    rob_idx_t i_br_idx;
    logic i_br_mispred;
    pc_t i_br_target;
    logic i_exc_vld;
    rob_idx_t i_exc_idx;
    exc_cause_t i_exc_cause;
    pc_t i_trap_vec;
    logic [`COMMIT_WIDTH-1:0] o_commit_vld;
    pc_t [`COMMIT_WIDTH-1:0] o_commit_pc;
    credit_t o_credit_return;
    logic o_squash_vld;
    pc_t o_squash_pc;
    logic o_squash_is_trap;
    pc_t o_epc;
    exc_cause_t o_exc_cause;

    // reference model, one entry per instruction still in the buffer
    logic [31:0] q_pc[$];
    rob_idx_t q_idx[$];
    bit q_done[$];
    bit q_mp[$];
    bit q_ex[$];

    int credits = `ROB_DEPTH;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit = 0;
    int br_cycle = 0;
    int ex_cycle = 0;
    bit past_branch = 0;
    bit squash_seen = 0;
    // tail pointer as the model sees it, never rewound by a flush
    rob_idx_t next_idx = '0;
    logic [31:0] mp_target;
    logic [31:0] sq_pc;
    logic [31:0] sq_epc;
    logic [3:0] sq_cause;
    logic sq_trap;
    logic [15:0] lfsr = 16'd87;

    rob_top rob_top_i (.*);

    always #50 clk = ~clk;

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = ^(lfsr & 16'hB400);
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("run stopped: cycle limit of %0d reached", limit);
            $display("ERRORS FOUND");
            $finish;
        end else if (!rst) begin
            credits += o_credit_return;
            for (int k = 0; k < `COMMIT_WIDTH; k++) begin
                if (o_commit_vld[k]) begin
                    if (q_pc.size() == 0) begin
                        errors++;
                        $display("commit with nothing outstanding at %0t", $time);
                    end else begin
                        if (q_ex[0] || past_branch) begin
                            errors++;
                            $display("instruction on a squashed path committed at %0t", $time);
                        end else if (!q_done[0]) begin
                            errors++;
                            $display("instruction committed before its writeback at %0t", $time);
                        end
                        check_val(o_commit_pc[k], q_pc[0], "commit pc");
                        // younger entries must never retire after this one
                        if (q_mp[0]) begin
                            past_branch = 1;
                            br_cycle = cycles;
                        end
                        void'(q_pc.pop_front());
                        void'(q_idx.pop_front());
                        void'(q_done.pop_front());
                        void'(q_mp.pop_front());
                        void'(q_ex.pop_front());
                    end
                end
            end
            if (o_squash_vld) begin
                // oldest remaining entry decides trap or branch redirect
                if (q_ex.size() > 0 && q_ex[0]) begin
                    check_val(o_squash_is_trap, 1'b1, "squash trap flag (model)");
                    check_val(o_epc, q_pc[0], "epc (model)");
                    check_val(cycles, ex_cycle + 3, "trap squash cycle after blocked commit");
                end else begin
                    check_val(o_squash_is_trap, 1'b0, "squash trap flag (model)");
                    check_val(o_squash_pc, mp_target, "squash target (model)");
                    check_val(cycles, br_cycle + 1, "squash cycle after branch");
                end
                sq_pc = o_squash_pc;
                sq_trap = o_squash_is_trap;
                sq_epc = o_epc;
                sq_cause = o_exc_cause;
                squash_seen = 1;
                past_branch = 0;
                ex_cycle = 0;
                // queue flushed at the edge that started this cycle
                q_pc.delete();
                q_idx.delete();
                q_done.delete();
                q_mp.delete();
                q_ex.delete();
            end else if (ex_cycle == 0 && !past_branch && q_ex.size() > 0) begin
                // excepting entry reaches the commit point in the coming cycle
                if (q_ex[0] || (q_ex.size() > 1 && q_ex[1] && q_done[0] && !q_mp[0])) begin
                    ex_cycle = cycles;
                end
            end
        end
    end

    // two per cycle at most, never beyond the credits held
    task automatic dispatch_n(input int n, input logic [31:0] pc);
        int m;
        while (n > 0) begin
            m = (n > `DISP_WIDTH) ? `DISP_WIDTH : n;
            m = (m > credits) ? credits : m;
            i_disp_vld = '0;
            for (int k = 0; k < m; k++) begin
                check_val(o_alloc_idx[k], next_idx, "alloc index");
                i_disp_vld[k] = 1'b1;
                i_disp_pc[k] = pc;
                q_pc.push_back(pc);
                q_idx.push_back(next_idx);
                q_done.push_back(0);
                q_mp.push_back(0);
                q_ex.push_back(0);
                next_idx = next_idx + 1'b1;
                pc = pc + 4;
            end
            credits -= m;
            n -= m;
            @(negedge clk);
        end
        i_disp_vld = '0;
    endtask

    task automatic writeback_all(input bit shuffled);
        rob_idx_t pend[$];
        int pos;
        foreach (q_idx[k]) begin
            if (!q_done[k] && !q_ex[k]) begin
                pend.push_back(q_idx[k]);
            end
        end
        while (pend.size() > 0) begin
            i_wb_vld = '0;
            for (int p = 0; p < `WB_PORTS && pend.size() > 0; p++) begin
                pos = 0;
                if (shuffled) begin
                    for (int b = 0; b < 4; b++) begin
                        pos = pos * 2 + lfsr_bit();
                    end
                    pos = pos % pend.size();
                end
                i_wb_vld[p] = 1'b1;
                i_wb_idx[p] = pend[pos];
                // done in the model from the edge that carries the writeback
                foreach (q_idx[k]) begin
                    if (q_idx[k] == pend[pos]) begin
                        q_done[k] = 1;
                    end
                end
                pend.delete(pos);
            end
            @(negedge clk);
        end
        i_wb_vld = '0;
    endtask

    task automatic mispredict(input int k, input logic [31:0] target);
        i_br_vld = 1'b1;
        i_br_mispred = 1'b1;
        i_br_idx = q_idx[k];
        i_br_target = target;
        q_done[k] = 1;
        q_mp[k] = 1;
        mp_target = target;
        @(negedge clk);
        i_br_vld = 1'b0;
        i_br_mispred = 1'b0;
    endtask

    task automatic raise_exception(input int k, input logic [3:0] cause);
        i_exc_vld = 1'b1;
        i_exc_idx = q_idx[k];
        i_exc_cause = cause;
        q_ex[k] = 1;
        @(negedge clk);
        i_exc_vld = 1'b0;
    endtask

    initial begin
        string lines[$];
        string line;
        string cmd;
        int fd;
        int a0;
        int a1;
        int a2;
        int a3;
        int tests;
        int err_start;
        rst = 1'b1;
        i_disp_vld = '0;
        i_disp_pc = '0;
        i_wb_vld = '0;
        i_wb_idx = '0;
        i_br_vld = 1'b0;
        i_br_idx = '0;
        i_br_mispred = 1'b0;
        i_br_target = '0;
        i_exc_vld = 1'b0;
        i_exc_idx = '0;
        i_exc_cause = '0;
        i_trap_vec = 32'h0000_0700;
        tests = 0;
        err_start = 0;
        fd = $fopen("dv/rob_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 1 && line[0] != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
            limit = 40 * lines.size() + 100;
            repeat (16) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            foreach (lines[i]) begin
                a0 = 0;
                a1 = 0;
                a2 = 0;
                a3 = 0;
                void'($sscanf(lines[i], "%s %h %h %h %h", cmd, a0, a1, a2, a3));
                case (cmd)
                    "D": dispatch_n(a0, a1);
                    "W": writeback_all(0);
                    "R": writeback_all(1);
                    "B": mispredict(a0, a1);
                    "E": raise_exception(a0, a1);
                    "I": repeat (a0) @(negedge clk);
                    "S": begin
                        while (!squash_seen) @(negedge clk);
                        squash_seen = 0;
                        check_val(sq_pc, a0, "squash pc");
                        check_val(sq_trap, a1, "squash trap flag");
                        if (a1 != 0) begin
                            check_val(sq_epc, a2, "epc");
                            check_val(sq_cause, a3, "exception cause");
                        end
                    end
                    "T": begin
                        // last commit empties the model, its credits show one cycle later
                        while (q_pc.size() != 0) @(negedge clk);
                        @(negedge clk);
                        check_val(credits, `ROB_DEPTH, "credits after drain");
                        tests++;
                        $display("test %0d: %s", a0, (errors == err_start) ? "pass" : "fail");
                        err_start = errors;
                    end
                    default: begin
                        errors++;
                        $display("unknown command in test data: %s", cmd);
                    end
                endcase
            end
            $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
            if (errors == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

// File: dv/rob_chk.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob_chk
    import rob_pkg::*;
(
    input logic                     clk,
    input logic                     rst,
    input logic [`COMMIT_WIDTH-1:0] o_commit_vld,
    input logic                     o_squash_vld,
    input credit_t                  o_credit_return
);

    // retire slots fill from slot 0 without gaps
    a_commit_contig : assert property (@(posedge clk) disable iff (rst)
        ((o_commit_vld & (o_commit_vld + 1'b1)) == '0))
        else $error("commit valid mask has a gap");

    // the squash cycle retires nothing
    a_no_commit_in_squash : assert property (@(posedge clk) disable iff (rst)
        o_squash_vld |-> (o_commit_vld == '0))
        else $error("commit during squash cycle");

    // squash is a single cycle pulse
    a_squash_pulse : assert property (@(posedge clk) disable iff (rst)
        o_squash_vld |=> !o_squash_vld)
        else $error("squash held for two cycles");

    a_credit_range : assert property (@(posedge clk) disable iff (rst)
        (o_credit_return <= `ROB_DEPTH))
        else $error("credit return above buffer depth");

endmodule

bind rob_top rob_chk rob_chk_i (.*);

// File: design/rob_top.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob_top
    import rob_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    // dispatch
    input  logic [`DISP_WIDTH-1:0]       i_disp_vld,
    input  pc_t [`DISP_WIDTH-1:0]        i_disp_pc,
    output rob_idx_t [`DISP_WIDTH-1:0]   o_alloc_idx,
    // completion
    input  logic [`WB_PORTS-1:0]         i_wb_vld,
    input  rob_idx_t [`WB_PORTS-1:0]     i_wb_idx,
    input  logic                         i_br_vld,
    input  rob_idx_t                     i_br_idx,
    input  logic                         i_br_mispred,
    input  pc_t                          i_br_target,
    input  logic                         i_exc_vld,
    input  rob_idx_t                     i_exc_idx,
    input  exc_cause_t                   i_exc_cause,
    // trap vector from the csr side
    input  pc_t                          i_trap_vec,
    // retire, credits and pipeline squash
    output logic [`COMMIT_WIDTH-1:0]     o_commit_vld,
    output pc_t [`COMMIT_WIDTH-1:0]      o_commit_pc,
    output credit_t                      o_credit_return,
    output logic                         o_squash_vld,
    output pc_t                          o_squash_pc,
    output logic                         o_squash_is_trap,
    output pc_t                          o_epc,
    output exc_cause_t                   o_exc_cause
);

    logic [`COMMIT_WIDTH-1:0] win_vld;
    logic [`COMMIT_WIDTH-1:0] win_done;
    rob_idx_t [`COMMIT_WIDTH-1:0] win_idx;
    pc_t [`COMMIT_WIDTH-1:0] win_pc;
    logic [`COMMIT_WIDTH-1:0] pop_mask;
    logic flush;
    credit_t flush_count;
    logic mp_held;
    rob_idx_t mp_idx;
    pc_t mp_target;
    logic ex_held;
    rob_idx_t ex_idx;
    exc_cause_t ex_cause;

    rob_entry_queue rob_entry_queue_i (
        .clk           (clk),
        .rst           (rst),
        .i_disp_vld    (i_disp_vld),
        .i_disp_pc     (i_disp_pc),
        .i_wb_vld      (i_wb_vld),
        .i_wb_idx      (i_wb_idx),
        .i_br_vld      (i_br_vld),
        .i_br_idx      (i_br_idx),
        .i_pop_mask    (pop_mask),
        .i_flush       (flush),
        .o_alloc_idx   (o_alloc_idx),
        .o_win_vld     (win_vld),
        .o_win_done    (win_done),
        .o_win_idx     (win_idx),
        .o_win_pc      (win_pc),
        .o_flush_count (flush_count)
    );

    oldest_mispred_tracker oldest_mispred_tracker_i (
        .clk          (clk),
        .rst          (rst),
        .i_br_vld     (i_br_vld),
        .i_br_idx     (i_br_idx),
        .i_br_mispred (i_br_mispred),
        .i_br_target  (i_br_target),
        .i_flush      (flush),
        .o_held       (mp_held),
        .o_idx        (mp_idx),
        .o_target     (mp_target)
    );

    oldest_except_tracker oldest_except_tracker_i (
        .clk         (clk),
        .rst         (rst),
        .i_exc_vld   (i_exc_vld),
        .i_exc_idx   (i_exc_idx),
        .i_exc_cause (i_exc_cause),
        .i_flush     (flush),
        .o_held      (ex_held),
        .o_idx       (ex_idx),
        .o_cause     (ex_cause)
    );

    commit_ctrl commit_ctrl_i (
        .clk              (clk),
        .rst              (rst),
        .i_win_vld        (win_vld),
        .i_win_done       (win_done),
        .i_win_idx        (win_idx),
        .i_win_pc         (win_pc),
        .i_mp_held        (mp_held),
        .i_mp_idx         (mp_idx),
        .i_mp_target      (mp_target),
        .i_ex_held        (ex_held),
        .i_ex_idx         (ex_idx),
        .i_ex_cause       (ex_cause),
        .i_flush_count    (flush_count),
        .i_trap_vec       (i_trap_vec),
        .o_pop_mask       (pop_mask),
        .o_flush          (flush),
        .o_commit_vld     (o_commit_vld),
        .o_commit_pc      (o_commit_pc),
        .o_credit_return  (o_credit_return),
        .o_squash_vld     (o_squash_vld),
        .o_squash_pc      (o_squash_pc),
        .o_squash_is_trap (o_squash_is_trap),
        .o_epc            (o_epc),
        .o_exc_cause      (o_exc_cause)
    );

endmodule

// File: design/commit_ctrl.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module commit_ctrl
    import rob_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`COMMIT_WIDTH-1:0]     i_win_vld,
    input  logic [`COMMIT_WIDTH-1:0]     i_win_done,
    input  rob_idx_t [`COMMIT_WIDTH-1:0] i_win_idx,
    input  pc_t [`COMMIT_WIDTH-1:0]      i_win_pc,
    input  logic                         i_mp_held,
    input  rob_idx_t                     i_mp_idx,
    input  pc_t                          i_mp_target,
    input  logic                         i_ex_held,
    input  rob_idx_t                     i_ex_idx,
    input  exc_cause_t                   i_ex_cause,
    input  credit_t                      i_flush_count,
    input  pc_t                          i_trap_vec,
    output logic [`COMMIT_WIDTH-1:0]     o_pop_mask,
    output logic                         o_flush,
    output logic [`COMMIT_WIDTH-1:0]     o_commit_vld,
    output pc_t [`COMMIT_WIDTH-1:0]      o_commit_pc,
    output credit_t                      o_credit_return,
    output logic                         o_squash_vld,
    output pc_t                          o_squash_pc,
    output logic                         o_squash_is_trap,
    output pc_t                          o_epc,
    output exc_cause_t                   o_exc_cause
);

    commit_state_t state_q;
    logic [`COMMIT_WIDTH-1:0] commit_mask;
    logic take_mp;
    logic take_ex;
    pc_t ex_pc;
    credit_t n_commit;

    logic squash_vld_q;
    logic squash_is_trap_q;
    pc_t squash_pc_q;
    pc_t epc_q;
    exc_cause_t cause_q;
    credit_t credit_q;

    // walk the window oldest first
    // stop before a faulting entry, or right after a mispredicted branch
    // whichever is older ends the walk, so only one of take_mp and take_ex rises
    always_comb begin
        logic reach;
        logic ex_hit;
        logic mp_hit;
        // nothing retires while the trap is being processed
        reach = (state_q == NORMAL);
        commit_mask = '0;
        take_mp = 1'b0;
        take_ex = 1'b0;
        ex_pc = i_win_pc[0];
        n_commit = '0;
        for (int k = 0; k < `COMMIT_WIDTH; k++) begin
            ex_hit = i_win_vld[k] && i_ex_held && (i_win_idx[k] == i_ex_idx);
            mp_hit = i_win_vld[k] && i_mp_held && (i_win_idx[k] == i_mp_idx);
            // faulting entry is not done, it is blocked here even so
            if (reach && ex_hit) begin
                take_ex = 1'b1;
                ex_pc = i_win_pc[k];
            end
            commit_mask[k] = reach && i_win_vld[k] && i_win_done[k] && !ex_hit;
            // branch itself retires, younger slots do not
            if (commit_mask[k] && mp_hit) begin
                take_mp = 1'b1;
            end
            n_commit = n_commit + credit_t'(commit_mask[k]);
            reach = commit_mask[k] && !mp_hit;
        end
    end

    // queue and trackers drop everything at the edge that starts the squash cycle
    assign o_flush = take_mp || (state_q == TRAP_PROCESS);
    assign o_pop_mask = commit_mask;
    assign o_commit_vld = commit_mask;
    assign o_commit_pc = i_win_pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= NORMAL;
            squash_vld_q <= 1'b0;
            squash_is_trap_q <= 1'b0;
            credit_q <= '0;
        end else begin
            // entries freed at this edge, by retire and by flush
            credit_q <= n_commit + i_flush_count;
            squash_vld_q <= o_flush;
            squash_is_trap_q <= (state_q == TRAP_PROCESS);
            case (state_q)
                NORMAL: begin
                    if (take_ex) begin
                        state_q <= TRAP_PROCESS;
                    end
                end
                // single stall cycle, squash follows
                TRAP_PROCESS: begin
                    state_q <= NORMAL;
                end
                default: begin
                    state_q <= NORMAL;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // fault pc and cause stay valid through the trap squash
        if (take_ex) begin
            epc_q <= ex_pc;
            cause_q <= i_ex_cause;
        end
        if (take_mp) begin
            squash_pc_q <= i_mp_target;
        end else if (state_q == TRAP_PROCESS) begin
            squash_pc_q <= i_trap_vec;
        end
    end

    assign o_credit_return = credit_q;
    assign o_squash_vld = squash_vld_q;
    assign o_squash_pc = squash_pc_q;
    assign o_squash_is_trap = squash_is_trap_q;
    assign o_epc = epc_q;
    assign o_exc_cause = cause_q;

endmodule

// File: design/oldest_except_tracker.sv
`timescale 1ns/1ps

module oldest_except_tracker
    import rob_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       i_exc_vld,
    input  rob_idx_t   i_exc_idx,
    input  exc_cause_t i_exc_cause,
    input  logic       i_flush,
    output logic       o_held,
    output rob_idx_t   o_idx,
    output exc_cause_t o_cause
);

    logic held_q;
    rob_idx_t idx_q;
    exc_cause_t cause_q;
    logic capture;

    // keep only the oldest fault, same age rule as the branch side
    assign capture = i_exc_vld && (!held_q || idx_older(i_exc_idx, idx_q));

    always_ff @(posedge clk) begin
        if (rst) begin
            held_q <= 1'b0;
        end else if (i_flush) begin
            held_q <= 1'b0;
        end else if (capture) begin
            held_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            idx_q <= i_exc_idx;
            cause_q <= i_exc_cause;
        end
    end

    assign o_held = held_q;
    assign o_idx = idx_q;
    assign o_cause = cause_q;

endmodule

// File: design/oldest_mispred_tracker.sv
`timescale 1ns/1ps

module oldest_mispred_tracker
    import rob_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     i_br_vld,
    input  rob_idx_t i_br_idx,
    input  logic     i_br_mispred,
    input  pc_t      i_br_target,
    input  logic     i_flush,
    output logic     o_held,
    output rob_idx_t o_idx,
    output pc_t      o_target
);

    logic held_q;
    rob_idx_t idx_q;
    pc_t target_q;
    logic capture;

    // correct predictions never replace anything
    // a younger mispredict loses to the one already held
    assign capture = i_br_vld && i_br_mispred && (!held_q || idx_older(i_br_idx, idx_q));

    always_ff @(posedge clk) begin
        if (rst) begin
            held_q <= 1'b0;
        end else if (i_flush) begin
            // whatever arrives during a flush belongs to the dead path
            held_q <= 1'b0;
        end else if (capture) begin
            held_q <= 1'b1;
        end
    end

    // index and target are only looked at while held
    always_ff @(posedge clk) begin
        if (capture) begin
            idx_q <= i_br_idx;
            target_q <= i_br_target;
        end
    end

    assign o_held = held_q;
    assign o_idx = idx_q;
    assign o_target = target_q;

endmodule

// File: design/rob_entry_queue.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob_entry_queue
    import rob_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`DISP_WIDTH-1:0]       i_disp_vld,
    input  pc_t [`DISP_WIDTH-1:0]        i_disp_pc,
    input  logic [`WB_PORTS-1:0]         i_wb_vld,
    input  rob_idx_t [`WB_PORTS-1:0]     i_wb_idx,
    input  logic                         i_br_vld,
    input  rob_idx_t                     i_br_idx,
    input  logic [`COMMIT_WIDTH-1:0]     i_pop_mask,
    input  logic                         i_flush,
    output rob_idx_t [`DISP_WIDTH-1:0]   o_alloc_idx,
    output logic [`COMMIT_WIDTH-1:0]     o_win_vld,
    output logic [`COMMIT_WIDTH-1:0]     o_win_done,
    output rob_idx_t [`COMMIT_WIDTH-1:0] o_win_idx,
    output pc_t [`COMMIT_WIDTH-1:0]      o_win_pc,
    output credit_t                      o_flush_count
);

    // per entry pc and completion flag
    pc_t pc_mem [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] done_q;

    // head is the oldest entry, tail the next free one
    rob_idx_t head_q;
    rob_idx_t tail_q;

    credit_t occupancy;
    credit_t n_disp;
    credit_t n_pop;
    rob_slot_t [`DISP_WIDTH-1:0] alloc_slot;

    // wrap bit makes the plain difference the fill level, 0 to ROB_DEPTH
    assign occupancy = tail_q - head_q;

    // masks are contiguous from slot 0, so a count is enough to move the pointers
    always_comb begin
        n_disp = '0;
        n_pop = '0;
        for (int k = 0; k < `DISP_WIDTH; k++) begin
            n_disp = n_disp + credit_t'(i_disp_vld[k]);
        end
        for (int k = 0; k < `COMMIT_WIDTH; k++) begin
            n_pop = n_pop + credit_t'(i_pop_mask[k]);
        end
    end

    // indices handed back to dispatch in the same cycle
    for (genvar k = 0; k < `DISP_WIDTH; k++) begin : g_alloc
        assign o_alloc_idx[k] = tail_q + rob_idx_t'(k);
        assign alloc_slot[k] = o_alloc_idx[k][$bits(rob_slot_t)-1:0];
    end

    // retire window, the oldest occupied entries in order
    for (genvar k = 0; k < `COMMIT_WIDTH; k++) begin : g_win
        rob_slot_t win_slot;
        assign o_win_idx[k] = head_q + rob_idx_t'(k);
        assign win_slot = o_win_idx[k][$bits(rob_slot_t)-1:0];
        assign o_win_vld[k] = (occupancy > credit_t'(k));
        assign o_win_done[k] = done_q[win_slot];
        assign o_win_pc[k] = pc_mem[win_slot];
    end

    // entries dropped by a flush
    // includes same-cycle dispatches, minus what commits at that edge
    assign o_flush_count = i_flush ? (occupancy + n_disp - n_pop) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            tail_q <= tail_q + n_disp;
            // flush empties the store, head catches up with the new tail
            if (i_flush) begin
                head_q <= tail_q + n_disp;
            end else begin
                head_q <= head_q + n_pop;
            end
        end
    end

    // done bits only matter for occupied entries, allocation clears them
    always_ff @(posedge clk) begin
        for (int w = 0; w < `WB_PORTS; w++) begin
            if (i_wb_vld[w]) begin
                done_q[i_wb_idx[w][$bits(rob_slot_t)-1:0]] <= 1'b1;
            end
        end
        // branch writeback also completes the branch
        if (i_br_vld) begin
            done_q[i_br_idx[$bits(rob_slot_t)-1:0]] <= 1'b1;
        end
        for (int k = 0; k < `DISP_WIDTH; k++) begin
            if (i_disp_vld[k]) begin
                pc_mem[alloc_slot[k]] <= i_disp_pc[k];
                done_q[alloc_slot[k]] <= 1'b0;
            end
        end
    end

endmodule

// File: design/rob_pkg.sv
`include "rob_consts.svh"

package rob_pkg;

    // slot inside the circular store
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_slot_t;

    // slot plus a wrap bit on top, so full and empty differ
    typedef logic [$clog2(`ROB_DEPTH):0] rob_idx_t;

    typedef logic [31:0] pc_t;
    typedef logic [3:0] exc_cause_t;

    // freed entries per cycle, 0 up to ROB_DEPTH
    typedef logic [$clog2(`ROB_DEPTH):0] credit_t;

    typedef enum logic [0:0] {
        NORMAL,
        TRAP_PROCESS
    } commit_state_t;

    // true when a is older than b
    // same wrap bit: lower slot is older, else the higher slot is older
    function automatic logic idx_older(rob_idx_t a, rob_idx_t b);
        logic same_flip;
        same_flip = (a[$bits(rob_idx_t)-1] == b[$bits(rob_idx_t)-1]);
        return same_flip ? (a[$bits(rob_slot_t)-1:0] < b[$bits(rob_slot_t)-1:0])
                         : (a[$bits(rob_slot_t)-1:0] > b[$bits(rob_slot_t)-1:0]);
    endfunction

endpackage

// File: design/rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// number of reorder buffer entries, power of two
`define ROB_DEPTH 16

// instructions accepted from dispatch per cycle
`define DISP_WIDTH 2

// instructions retired per cycle
`define COMMIT_WIDTH 2

// plain completion writeback ports
// branch and exception writebacks come on their own ports
`define WB_PORTS 2

`endif
